// ==== include/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_WAYS      2
`define DC_SETS      16
`define DC_WORDS     4    // 32-bit words per line
`define DC_OFFSET_W  4    // byte offset within a line
`define DC_INDEX_W   4
`define DC_TAG_W     24   // 32 - index - offset

// every bus transfer is a whole line
`define DC_BURST_LEN 4

`endif

// ==== hw/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    // one buffered cpu request
    typedef struct packed {
        logic        op;     // 1 store, 0 load
        logic [31:0] addr;
        logic [3:0]  wstrb;  // byte mask, also the access size
        logic [31:0] wdata;
    } cache_req_t;

    // per way, per set
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    // word 0 sits in the low bits
    typedef logic [`DC_WORDS-1:0][31:0] line_t;

    // miss buffer contents
    typedef struct packed {
        logic                   way;
        tag_entry_t             entry;
        logic [`DC_INDEX_W-1:0] index;
    } victim_t;

endpackage

// ==== hw/dcache_ctrl.sv ====
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid,
    input  logic                                op,
    input  logic [31:0]                         addr,
    input  logic [3:0]                          write_type,
    input  logic [31:0]                         w_data_cpu,
    input  logic                                hit,
    input  logic                                hit_way,
    input  dcache_pkg::tag_entry_t              victim,
    input  dcache_pkg::line_t [`DC_WAYS-1:0]    way_data,
    input  dcache_pkg::line_t                   fill_line,
    input  logic                                fill_done,
    input  logic                                wb_done,
    output logic                                data_valid,
    output logic [31:0]                         r_data_cpu,
    output logic                                exception,
    output logic [`DC_INDEX_W-1:0]              lookup_index,
    output logic                                tag_we,
    output logic                                data_we,
    output logic                                wr_way,
    output dcache_pkg::line_t                   wr_line,
    output dcache_pkg::tag_entry_t              wr_tag,
    output logic                                lru_touch,
    output logic                                fill_start,
    output logic                                wb_start,
    output dcache_pkg::line_t                   wb_line,
    output logic [31:0]                         line_addr_rd,
    output logic [31:0]                         line_addr_wb
);

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_WB, S_FILL, S_RESP} state_t;

    state_t                 state;
    dcache_pkg::cache_req_t req_q;   // request buffer
    dcache_pkg::victim_t    mbuf;    // miss buffer
    dcache_pkg::line_t      base_line;
    logic [31:0]            rdata_q;
    logic                   exc_q;
    logic                   misaligned;
    logic                   hit_acc;
    logic                   fill_acc;
    logic [1:0]             word_sel;

    assign word_sel     = req_q.addr[`DC_OFFSET_W-1:2];
    assign lookup_index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign line_addr_rd = {req_q.addr[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign line_addr_wb = {mbuf.entry.tag, mbuf.index, {`DC_OFFSET_W{1'b0}}};
    assign wb_line      = way_data[mbuf.way];   // index is still the request's

    // access size comes from the byte mask
    always_comb begin
        case (req_q.wstrb)
            4'b1111:          misaligned = |req_q.addr[1:0];
            4'b0011, 4'b1100: misaligned = req_q.addr[0];
            default:          misaligned = 1'b0;
        endcase
    end

    assign hit_acc  = (state == S_LOOKUP) && hit && !misaligned;
    assign fill_acc = (state == S_FILL) && fill_done;

    // store merge into the hit line or the refilled line
    always_comb begin
        base_line = (state == S_FILL) ? fill_line : way_data[hit_way];
        wr_line   = base_line;
        if (req_q.op) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.wstrb[b])
                    wr_line[word_sel][8*b +: 8] = req_q.wdata[8*b +: 8];
            end
        end
    end

    assign wr_way    = (state == S_FILL) ? mbuf.way : hit_way;
    assign data_we   = (hit_acc && req_q.op) || fill_acc;
    assign tag_we    = data_we;
    assign lru_touch = hit_acc || fill_acc;
    assign wr_tag    = '{valid: 1'b1, dirty: req_q.op, tag: req_q.addr[31 -: `DC_TAG_W]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            fill_start <= 1'b0;
            wb_start   <= 1'b0;
            exc_q      <= 1'b0;
        end else begin
            fill_start <= 1'b0;
            wb_start   <= 1'b0;
            case (state)
                S_IDLE: if (valid) state <= S_LOOKUP;
                S_LOOKUP: begin
                    exc_q <= misaligned;
                    if (misaligned || hit) begin
                        state <= S_RESP;
                    end else if (victim.valid && victim.dirty) begin
                        state    <= S_WB;   // write back before refill
                        wb_start <= 1'b1;
                    end else begin
                        state      <= S_FILL;
                        fill_start <= 1'b1;
                    end
                end
                S_WB: begin
                    if (wb_done) begin
                        state      <= S_FILL;
                        fill_start <= 1'b1;
                    end
                end
                S_FILL: if (fill_done) state <= S_RESP;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && valid)
            req_q <= '{op: op, addr: addr, wstrb: write_type, wdata: w_data_cpu};
        if (state == S_LOOKUP)
            mbuf <= '{way: hit_way, entry: victim, index: lookup_index};
        if (hit_acc || fill_acc)
            rdata_q <= wr_line[word_sel];
    end

    assign data_valid = (state == S_RESP);
    assign exception  = (state == S_RESP) && exc_q;
    assign r_data_cpu = rdata_q;

    // bus port only finishes what this FSM is waiting on
    a_fill_done: assert property (@(posedge clk) disable iff (rst)
        fill_done |-> state == S_FILL);
    a_wb_done: assert property (@(posedge clk) disable iff (rst)
        wb_done |-> state == S_WB);
    a_valid_idle: assert property (@(posedge clk) disable iff (rst)
        valid |-> state == S_IDLE);   // one request at a time

endmodule

// ==== hw/dcache_arrays.sv ====
`include "dcache_consts.svh"

module dcache_arrays (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [`DC_INDEX_W-1:0]              lookup_index,
    input  logic [`DC_TAG_W-1:0]                lookup_tag,
    input  logic                                tag_we,
    input  logic                                data_we,
    input  logic                                wr_way,
    input  dcache_pkg::line_t                   wr_line,
    input  dcache_pkg::tag_entry_t              wr_tag,
    input  logic                                lru_touch,
    output logic                                hit,
    output logic                                hit_way,
    output dcache_pkg::tag_entry_t              victim,
    output dcache_pkg::line_t [`DC_WAYS-1:0]    way_data
);

    dcache_pkg::tag_entry_t tags  [`DC_WAYS][`DC_SETS];
    dcache_pkg::line_t      lines [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0]    lru;       // way to evict next
    logic [`DC_WAYS-1:0]    hit_vec;
    logic                   repl_way;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_data[w] = lines[w][lookup_index];
            hit_vec[w]  = tags[w][lookup_index].valid &&
                          (tags[w][lookup_index].tag == lookup_tag);
        end
    end

    // empty way first, else lru
    always_comb begin
        if (!tags[0][lookup_index].valid)
            repl_way = 1'b0;
        else if (!tags[1][lookup_index].valid)
            repl_way = 1'b1;
        else
            repl_way = lru[lookup_index];
    end

    assign hit     = |hit_vec;
    assign hit_way = hit ? hit_vec[1] : repl_way;   // names the victim on a miss
    assign victim  = tags[repl_way][lookup_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                for (int s = 0; s < `DC_SETS; s++) begin
                    tags[w][s].valid <= 1'b0;
                    tags[w][s].dirty <= 1'b0;
                end
            end
            lru <= '0;
        end else begin
            if (tag_we)
                tags[wr_way][lookup_index] <= wr_tag;
            if (lru_touch)
                lru[lookup_index] <= ~wr_way;   // other way becomes lru
        end
    end

    always_ff @(posedge clk) begin
        if (data_we)
            lines[wr_way][lookup_index] <= wr_line;
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst) !(&hit_vec));

endmodule

// ==== hw/dcache_bus_port.sv ====
`include "dcache_consts.svh"

module dcache_bus_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               fill_start,
    input  logic               wb_start,
    input  dcache_pkg::line_t  wb_line,
    input  logic [31:0]        line_addr_rd,
    input  logic [31:0]        line_addr_wb,
    input  logic               r_rdy,
    input  logic               ret_valid,
    input  logic               ret_last,
    input  logic [31:0]        r_data_bus,
    input  logic               w_rdy,
    input  logic               w_data_ready,
    input  logic               b_valid,
    output dcache_pkg::line_t  fill_line,
    output logic               fill_done,
    output logic               wb_done,
    output logic               r_req,
    output logic [31:0]        r_addr,
    output logic               r_data_ready,
    output logic               w_req,
    output logic [31:0]        w_addr,
    output logic               w_data_req,
    output logic [31:0]        w_data_bus,
    output logic [3:0]         w_strb,
    output logic               w_last,
    output logic               b_ready
);

    localparam int BEAT_W = $clog2(`DC_BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DC_BURST_LEN - 1);

    typedef enum logic [1:0] {R_IDLE, R_REQ, R_DATA} rd_state_t;
    typedef enum logic [1:0] {W_IDLE, W_REQ, W_DATA, W_RESP} wr_state_t;

    rd_state_t         rd_state;
    wr_state_t         wr_state;
    logic [BEAT_W-1:0] rd_cnt;
    logic [BEAT_W-1:0] wr_cnt;
    dcache_pkg::line_t wb_buf;    // shifts one word per beat

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state  <= R_IDLE;
            rd_cnt    <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (rd_state)
                R_IDLE: if (fill_start) rd_state <= R_REQ;
                R_REQ: begin
                    if (r_rdy) begin
                        rd_state <= R_DATA;
                        rd_cnt   <= '0;
                    end
                end
                default: begin
                    if (ret_valid) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (ret_last) begin
                            rd_state  <= R_IDLE;
                            fill_done <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == R_IDLE && fill_start)
            r_addr <= line_addr_rd;
        if (rd_state == R_DATA && ret_valid)
            fill_line[rd_cnt] <= r_data_bus;   // beat k is word k
        if (wr_state == W_IDLE && wb_start) begin
            w_addr <= line_addr_wb;
            wb_buf <= wb_line;
        end else if (wr_state == W_DATA && w_data_ready) begin
            wb_buf <= {32'b0, wb_buf[`DC_WORDS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= W_IDLE;
            wr_cnt   <= '0;
            wb_done  <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            case (wr_state)
                W_IDLE: if (wb_start) wr_state <= W_REQ;
                W_REQ: begin
                    if (w_rdy) begin
                        wr_state <= W_DATA;
                        wr_cnt   <= '0;
                    end
                end
                W_DATA: begin
                    if (w_data_ready) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt == LAST_BEAT)
                            wr_state <= W_RESP;
                    end
                end
                default: begin
                    if (b_valid) begin
                        wr_state <= W_IDLE;
                        wb_done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign r_req        = (rd_state == R_REQ);
    assign r_data_ready = (rd_state == R_DATA);
    assign w_req        = (wr_state == W_REQ);
    assign w_data_req   = (wr_state == W_DATA);
    assign w_last       = (wr_state == W_DATA) && (wr_cnt == LAST_BEAT);
    assign b_ready      = (wr_state == W_RESP);
    assign w_data_bus   = wb_buf[0];
    assign w_strb       = 4'b1111;   // full words only

    a_last_beat: assert property (@(posedge clk) disable iff (rst)
        (rd_state == R_DATA && ret_valid && ret_last) |-> rd_cnt == LAST_BEAT);

endmodule

// ==== hw/dcache_top.sv ====
`include "dcache_consts.svh"

module dcache_top (
    input  logic        clk,
    input  logic        rst,
    // cpu side
    input  logic        valid,
    input  logic        op,            // 1 store, 0 load
    input  logic [31:0] addr,
    input  logic [3:0]  write_type,    // byte mask
    input  logic [31:0] w_data_cpu,
    output logic        data_valid,
    output logic [31:0] r_data_cpu,
    output logic        exception,
    // bus read channel
    output logic        r_req,
    output logic [31:0] r_addr,
    input  logic        r_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] r_data_bus,
    output logic        r_data_ready,
    // bus write channel
    output logic        w_req,
    output logic [31:0] w_addr,
    input  logic        w_rdy,
    output logic        w_data_req,
    output logic [31:0] w_data_bus,
    output logic [3:0]  w_strb,
    output logic        w_last,
    input  logic        w_data_ready,
    input  logic        b_valid,
    output logic        b_ready
);

    logic [`DC_INDEX_W-1:0]             lookup_index;
    logic                               tag_we;
    logic                               data_we;
    logic                               wr_way;
    logic                               lru_touch;
    logic                               hit;
    logic                               hit_way;
    logic                               fill_start;
    logic                               wb_start;
    logic                               fill_done;
    logic                               wb_done;
    logic [31:0]                        line_addr_rd;
    logic [31:0]                        line_addr_wb;
    dcache_pkg::line_t                  wr_line;
    dcache_pkg::line_t                  wb_line;
    dcache_pkg::line_t                  fill_line;
    dcache_pkg::line_t [`DC_WAYS-1:0]   way_data;
    dcache_pkg::tag_entry_t             wr_tag;
    dcache_pkg::tag_entry_t             victim;

    dcache_ctrl ctrl0 (.*);

    // lookup tag is the request's line address
    dcache_arrays arrays0 (
        .lookup_tag (line_addr_rd[31 -: `DC_TAG_W]),
        .*
    );

    dcache_bus_port bus0 (.*);

endmodule

// ==== bench/dcache_mem_model.sv ====
`include "dcache_consts.svh"

module dcache_mem_model #(
    parameter int READY_DLY = 3    // cycles before r_rdy / w_rdy
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        r_req,
    input  logic [31:0] r_addr,
    output logic        r_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output logic [31:0] r_data_bus,
    input  logic        r_data_ready,
    input  logic        w_req,
    input  logic [31:0] w_addr,
    output logic        w_rdy,
    input  logic        w_data_req,
    input  logic [31:0] w_data_bus,
    input  logic [3:0]  w_strb,
    input  logic        w_last,
    output logic        w_data_ready,
    output logic        b_valid,
    input  logic        b_ready
);

    localparam int MEM_WORDS = 4096;

    logic [31:0] mem [MEM_WORDS];
    logic [9:0]  rd_line;
    logic [9:0]  wr_line;
    logic [1:0]  rd_beat;
    logic [1:0]  wr_beat;
    logic        rd_active;
    int          rd_wait;
    int          wr_wait;

    // low half is the byte address, high half a scrambled copy
    function automatic logic [31:0] fill_word(input int k);
        logic [15:0] a;
        a = 16'(k * 4);
        return {a ^ 16'h3c5a, a};
    endfunction

    function automatic logic [31:0] peek(input logic [11:0] k);
        return mem[k];
    endfunction

    initial begin
        for (int k = 0; k < MEM_WORDS; k++)
            mem[k[11:0]] = fill_word(k);
        r_rdy        = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        r_data_bus   = '0;
        w_rdy        = 1'b0;
        w_data_ready = 1'b0;
        b_valid      = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            r_rdy     <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            rd_active <= 1'b0;
            rd_wait   <= 0;
        end else begin
            r_rdy     <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (rd_active) begin
                if (r_data_ready) begin   // one beat per cycle
                    ret_valid  <= 1'b1;
                    r_data_bus <= mem[{rd_line, rd_beat}];
                    ret_last   <= (rd_beat == 2'd3);
                    rd_beat    <= rd_beat + 2'd1;
                    if (rd_beat == 2'd3)
                        rd_active <= 1'b0;
                end
            end else if (r_req && r_rdy) begin
                rd_active <= 1'b1;
                rd_line   <= r_addr[13:4];
                rd_beat   <= 2'd0;
                rd_wait   <= 0;
            end else if (r_req) begin
                if (rd_wait == READY_DLY)
                    r_rdy <= 1'b1;
                else
                    rd_wait <= rd_wait + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            w_rdy        <= 1'b0;
            w_data_ready <= 1'b0;
            b_valid      <= 1'b0;
            wr_wait      <= 0;
        end else begin
            w_rdy <= 1'b0;
            if (b_valid) begin
                if (b_ready)
                    b_valid <= 1'b0;
            end else if (w_data_ready) begin
                if (w_data_req) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b])
                            mem[{wr_line, wr_beat}][8*b +: 8] <= w_data_bus[8*b +: 8];
                    end
                    wr_beat <= wr_beat + 2'd1;
                    if (w_last) begin
                        w_data_ready <= 1'b0;
                        b_valid      <= 1'b1;   // response right after the last beat
                    end
                end
            end else if (w_req && w_rdy) begin
                w_data_ready <= 1'b1;
                wr_line      <= w_addr[13:4];
                wr_beat      <= 2'd0;
                wr_wait      <= 0;
            end else if (w_req) begin
                if (wr_wait == READY_DLY)
                    w_rdy <= 1'b1;
                else
                    wr_wait <= wr_wait + 1;
            end
        end
    end

endmodule

// ==== bench/dcache_tb.sv ====
`include "dcache_consts.svh"

module dcache_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int ACCESS_LIMIT = 200;   // cycles allowed per access
    localparam int RAND_OPS     = 40;
    localparam int N_ACCESSES   = 20 + RAND_OPS;
    localparam int MEM_WORDS    = 4096;

    logic        clk;
    logic        rst;
    logic        valid;
    logic        op;
    logic [31:0] addr;
    logic [3:0]  write_type;
    logic [31:0] w_data_cpu;
    logic        data_valid;
    logic [31:0] r_data_cpu;
    logic        exception;
    logic        r_req;
    logic [31:0] r_addr;
    logic        r_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] r_data_bus;
    logic        r_data_ready;
    logic        w_req;
    logic [31:0] w_addr;
    logic        w_rdy;
    logic        w_data_req;
    logic [31:0] w_data_bus;
    logic [3:0]  w_strb;
    logic        w_last;
    logic        w_data_ready;
    logic        b_valid;
    logic        b_ready;

    logic [31:0] ref_mem [MEM_WORDS];   // what memory should hold
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          rd_bursts = 0;
    int          wb_bursts = 0;
    int          seed;

    dcache_top dut0 (.*);
    dcache_mem_model mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + ACCESS_LIMIT * N_ACCESSES));
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    // address handshakes, one cycle each
    always @(negedge clk) begin
        if (r_req && r_rdy)
            rd_bursts++;
        if (w_req && w_rdy)
            wb_bursts++;
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // size comes from the number of bytes in the mask
    function automatic logic misaligned_access(input logic [31:0] a, input logic [3:0] mask);
        case ($countones(mask))
            4:       return a[1:0] != 2'b00;
            2:       return a[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic dcache_pkg::line_t mem_line(input logic [31:0] a);
        dcache_pkg::line_t l;
        for (int w = 0; w < `DC_WORDS; w++)
            l[w[1:0]] = mem0.peek({a[13:4], w[1:0]});
        return l;
    endfunction

    function automatic dcache_pkg::line_t ref_line(input logic [31:0] a);
        dcache_pkg::line_t l;
        for (int w = 0; w < `DC_WORDS; w++)
            l[w[1:0]] = ref_mem[{a[13:4], w[1:0]}];
        return l;
    endfunction

    task automatic run_access(input logic is_store, input logic [31:0] a, input logic [3:0] mask,
                              input logic [31:0] wd, output logic [31:0] rd, output int lat);
        lat = 0;
        @(posedge clk);
        #1;
        valid      = 1'b1;
        op         = is_store;
        addr       = a;
        write_type = mask;
        w_data_cpu = wd;
        @(posedge clk);
        #1;
        valid = 1'b0;
        do begin
            @(negedge clk);
            lat++;
        end while (!data_valid && lat < ACCESS_LIMIT);
        if (!data_valid) begin
            $display("no data_valid within %0d cycles for the access to %h", ACCESS_LIMIT, a);
            errors++;
        end
        rd = r_data_cpu;
        check_flag("exception", exception, misaligned_access(a, mask));
    endtask

    task automatic cpu_read(input logic [31:0] a, input logic [3:0] mask, output int lat);
        logic [31:0] rd;
        run_access(1'b0, a, mask, 32'h0, rd, lat);
        if (!misaligned_access(a, mask))
            check_word("r_data_cpu", rd, ref_mem[a[13:2]]);
    endtask

    task automatic cpu_write(input logic [31:0] a, input logic [3:0] mask, input logic [31:0] wd,
                             output int lat);
        logic [31:0] rd;
        run_access(1'b1, a, mask, wd, rd, lat);
        if (!misaligned_access(a, mask)) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b])
                    ref_mem[a[13:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, errors - e0);
        end
    endtask

    task automatic test_cold_miss();
        int e0;
        int lat;
        int r0;
        e0 = errors;
        cpu_read(32'h010, 4'b1111, lat);
        check_word("read bursts", rd_bursts, 1);
        r0 = rd_bursts;
        cpu_read(32'h018, 4'b1111, lat);   // same line, now a hit
        check_word("hit latency", lat, 2);
        check_word("read bursts", rd_bursts, r0);
        report_test("cold read miss", e0);
    endtask

    task automatic test_masked_writes();
        int e0;
        int lat;
        int r0;
        int w0;
        e0 = errors;
        r0 = rd_bursts;
        w0 = wb_bursts;
        cpu_write(32'h014, 4'b0001, $random(seed), lat);
        check_word("hit latency", lat, 2);
        cpu_write(32'h018, 4'b1100, $random(seed), lat);
        check_word("hit latency", lat, 2);
        cpu_write(32'h01c, 4'b1111, $random(seed), lat);
        check_word("hit latency", lat, 2);
        for (int i = 0; i < 3; i++)
            cpu_read(32'h014 + 4 * i, 4'b1111, lat);
        check_word("read bursts", rd_bursts, r0);
        check_word("write-back bursts", wb_bursts, w0);
        report_test("masked write hits", e0);
    endtask

    task automatic test_eviction();
        int e0;
        int lat;
        int w0;
        e0 = errors;
        cpu_write(32'h020, 4'b1111, $random(seed), lat);   // way 0, dirty
        cpu_read(32'h124, 4'b1111, lat);                   // way 1, clean
        w0 = wb_bursts;
        cpu_read(32'h228, 4'b1111, lat);                   // evicts the dirty line
        check_word("write-back bursts", wb_bursts, w0 + 1);
        check_line("memory line 020", mem_line(32'h020), ref_line(32'h020));
        cpu_read(32'h32c, 4'b1111, lat);                   // evicts the clean line
        check_word("write-back bursts", wb_bursts, w0 + 1);
        report_test("lru eviction", e0);
    endtask

    task automatic test_write_miss();
        int e0;
        int lat;
        int r0;
        e0 = errors;
        r0 = rd_bursts;
        cpu_write(32'h034, 4'b0110, $random(seed), lat);
        check_word("read bursts", rd_bursts, r0 + 1);
        cpu_read(32'h034, 4'b1111, lat);
        check_word("hit latency", lat, 2);
        report_test("write miss allocate", e0);
    endtask

    task automatic test_misaligned();
        int e0;
        int lat;
        int r0;
        int w0;
        e0 = errors;
        r0 = rd_bursts;
        w0 = wb_bursts;
        cpu_read(32'h011, 4'b1111, lat);
        check_word("exception latency", lat, 2);
        cpu_write(32'h015, 4'b1111, $random(seed), lat);
        check_word("exception latency", lat, 2);
        cpu_write(32'h013, 4'b0011, $random(seed), lat);
        check_word("exception latency", lat, 2);
        cpu_read(32'h041, 4'b1111, lat);    // uncached line, must not refill
        check_word("exception latency", lat, 2);
        check_word("read bursts", rd_bursts, r0);
        check_word("write-back bursts", wb_bursts, w0);
        cpu_read(32'h014, 4'b1111, lat);
        cpu_read(32'h010, 4'b1111, lat);
        report_test("misaligned access", e0);
    endtask

    task automatic test_random_mix();
        int          e0;
        int          lat;
        logic [31:0] r;
        logic [31:0] a;
        logic [3:0]  mask;
        e0 = errors;
        for (int i = 0; i < RAND_OPS; i++) begin
            r = $random(seed);
            // four tags over sets 4 and 5
            a = {22'd0, r[2:1], 3'b010, r[0], r[4:3], 2'b00};
            mask = (r[8:5] == 4'b0000) ? 4'b1111 : r[8:5];
            if (r[9])
                cpu_write(a, mask, $random(seed), lat);
            else
                cpu_read(a, 4'b1111, lat);
        end
        report_test("random mix", e0);
    endtask

    initial begin
        seed       = 32'h7d033276;
        rst        = 1'b1;
        valid      = 1'b0;
        op         = 1'b0;
        addr       = '0;
        write_type = '0;
        w_data_cpu = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < MEM_WORDS; k++)
            ref_mem[k[11:0]] = mem0.peek(k[11:0]);
        test_cold_miss();
        test_masked_writes();
        test_eviction();
        test_write_miss();
        test_misaligned();
        test_random_mix();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
hw/dcache_pkg.sv
hw/dcache_ctrl.sv
hw/dcache_arrays.sv
hw/dcache_bus_port.sv
hw/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = dcache_tb
RTL_TOP    = dcache_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
LOG        = run.log
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
